/* project.f */
+incdir+include
verilog/core_mem_pkg.sv
verilog/fetch_unit.sv
verilog/load_store_unit.sv
verilog/l15_port_arbiter.sv
verilog/core_mem_subsys.sv
bench/core_mem_asserts.sv
bench/tb_core_mem_subsys.sv

/* bench/tb_core_mem_subsys.sv */
`include "core_mem_defs.svh"

module tb_core_mem_subsys;

	localparam int PHASES       = 3;
	localparam int PHASE_CYCLES = 700;
	localparam int LIMIT_CYCLES = 2000 * PHASES;

	logic                      clk;
	logic                      nrst;
	logic                      redirect;
	logic [31:0]               redirect_target;
	logic                      fetch_stall;
	logic                      fetch_valid;
	core_mem_pkg::fetch_out_t  fetch_out;
	logic                      lsu_cmd_valid;
	core_mem_pkg::lsu_cmd_t    lsu_cmd;
	logic                      lsu_busy;
	logic                      lsu_result_valid;
	core_mem_pkg::lsu_result_t lsu_result;
	core_mem_pkg::l15_req_t    l15_req;
	logic                      l15_req_val;
	logic                      l15_header_ack;
	logic                      l15_resp_val;
	core_mem_pkg::l15_resp_t   l15_resp;
	logic                      l15_req_ack;

	integer                 seed;
	logic [63:0]            mem [0:255];    // Responder memory
	logic [7:0]             shadow [0:2047]; // Model memory, byte addressed
	logic [31:0]            exp_pc;
	logic                   pending;        // Command issued, result not yet seen
	core_mem_pkg::lsu_cmd_t cur_cmd;
	int                     fetch_count;
	int                     lsu_count;
	int                     fetch_mark;     // Counts at the start of a phase
	int                     lsu_mark;

	core_mem_subsys u_core_mem_subsys (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic int access_bytes(input core_mem_pkg::lsu_op_e op);
		case (op)
			core_mem_pkg::LSU_LB, core_mem_pkg::LSU_LBU, core_mem_pkg::LSU_SB: return 1;
			core_mem_pkg::LSU_LH, core_mem_pkg::LSU_LHU, core_mem_pkg::LSU_SH: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic logic is_store_op(input core_mem_pkg::lsu_op_e op);
		return op == core_mem_pkg::LSU_SB || op == core_mem_pkg::LSU_SH ||
			op == core_mem_pkg::LSU_SW;
	endfunction

	function automatic logic [31:0] read_bytes(input logic [31:0] addr, input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = shadow[(addr + i) & 32'h7ff];
		return v;
	endfunction

	// Expected load value from the model bytes
	function automatic logic [31:0] load_value(input core_mem_pkg::lsu_cmd_t c);
		logic [31:0] raw;
		raw = read_bytes(c.addr, access_bytes(c.op));
		case (c.op)
			core_mem_pkg::LSU_LB: return {{24{raw[7]}}, raw[7:0]};
			core_mem_pkg::LSU_LH: return {{16{raw[15]}}, raw[15:0]};
			default:              return raw;
		endcase
	endfunction

	task automatic observe();
		logic misal;
		if (fetch_valid)
		begin
			check_value("fetch pc", fetch_out.pc, exp_pc);
			check_value("fetch instr", fetch_out.instr, read_bytes(exp_pc, 4));
			exp_pc = exp_pc + 32'd4;
			fetch_count++;
		end
		if (pending && !lsu_result_valid)
			check_value("lsu busy", lsu_busy, 1'b1);
		if (lsu_result_valid)
		begin
			check_value("result while idle", pending, 1'b1);
			misal = (cur_cmd.addr % access_bytes(cur_cmd.op)) != 0;
			if (!misal)
				check_value("lsu busy after result", lsu_busy, 1'b0);
			check_value("result tag", lsu_result.tag, cur_cmd.tag);
			check_value("misaligned flag", lsu_result.misaligned, misal);
			if (misal || is_store_op(cur_cmd.op))
				check_value("result data", lsu_result.data, 32'b0);
			else
				check_value("load data", lsu_result.data, load_value(cur_cmd));
			if (!misal && is_store_op(cur_cmd.op))
				for (int i = 0; i < access_bytes(cur_cmd.op); i++)
					shadow[(cur_cmd.addr + i) & 32'h7ff] = cur_cmd.data[8*i +: 8];
			pending = 1'b0;
			lsu_count++;
		end
	endtask

	task automatic drive(input int phase);
		logic [31:0] r;
		r = $random(seed);
		redirect      = 1'b0;
		lsu_cmd_valid = 1'b0;
		fetch_stall   = (phase == 1) ? (r[1:0] == 2'b00) : (phase == 2 && r[4:2] != 3'b000);
		if (phase != 2 && r[9:6] == 4'h0)
		begin
			redirect        = 1'b1;
			redirect_target = $random(seed) & 32'h7fc;
			exp_pc          = redirect_target;
		end
		if (phase != 0 && !pending && !lsu_busy && (phase == 2 || r[12]))
		begin
			lsu_cmd.op  = core_mem_pkg::lsu_op_e'(r[15:13]);
			lsu_cmd.tag = r[20:16];
			lsu_cmd.data = $random(seed);
			if (r[22:21] != 2'b00 || lsu_count == 0)    // Otherwise reuse the last address
				lsu_cmd.addr = $random(seed) & 32'h7ff;
			cur_cmd       = lsu_cmd;
			lsu_cmd_valid = 1'b1;
			pending       = 1'b1;
		end
	endtask

	// L1.5 responder with its own memory
	task automatic serve();
		core_mem_pkg::l15_req_t rq;
		int                     d;
		d = $random(seed) & 3;
		repeat (d)
		begin
			@(posedge clk);
			#1;
		end
		rq = l15_req;
		if (rq.rqtype == `L15_RQ_IFILL)
		begin
			check_value("ifill size", rq.size, `L15_SIZE_4B);
			check_value("ifill alignment", rq.address[1:0], 2'b00);
		end
		else
		begin
			check_value("lsu request expected", pending, 1'b1);
			check_value("lsu address", rq.address, cur_cmd.addr);
			check_value("aligned access", cur_cmd.addr % access_bytes(cur_cmd.op), 0);
			check_value("lsu rqtype", rq.rqtype,
				is_store_op(cur_cmd.op) ? `L15_RQ_STORE : `L15_RQ_LOAD);
			check_value("lsu size", rq.size, access_bytes(cur_cmd.op) == 1 ? `L15_SIZE_1B :
				access_bytes(cur_cmd.op) == 2 ? `L15_SIZE_2B : `L15_SIZE_4B);
		end
		l15_header_ack = 1'b1;
		@(posedge clk);
		#1;
		l15_header_ack = 1'b0;
		d = ($random(seed) & 3) + 1;
		repeat (d - 1)
		begin
			@(posedge clk);
			#1;
		end
		if (rq.rqtype == `L15_RQ_STORE)
		begin
			for (int i = 0; i < (1 << rq.size); i++)
				mem[rq.address[10:3]][8*(rq.address[2:0] + i) +: 8] = rq.data[8*i +: 8];
			l15_resp.rtntype = `L15_RT_ST_ACK;
		end
		else
			l15_resp.rtntype = (rq.rqtype == `L15_RQ_IFILL) ? `L15_RT_IFILL : `L15_RT_LOAD;
		l15_resp.data = mem[rq.address[10:3]];
		l15_resp_val  = 1'b1;
		#1;
		check_value("request ack", l15_req_ack, 1'b1);
		@(posedge clk);
		#1;
		l15_resp_val = 1'b0;
	endtask

	initial
	begin
		@(posedge nrst);
		forever
		begin
			@(posedge clk);
			#1;
			if (l15_req_val)
				serve();
		end
	end

	initial
	begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timeout: the run hung and did not finish its test phases");
		$display("Simulation failed");
		$fatal(1);
	end

	initial
	begin
		seed            = 74;
		nrst            = 1'b0;
		redirect        = 1'b0;
		redirect_target = '0;
		fetch_stall     = 1'b0;
		lsu_cmd_valid   = 1'b0;
		lsu_cmd         = '0;
		l15_header_ack  = 1'b0;
		l15_resp_val    = 1'b0;
		l15_resp        = '0;
		exp_pc          = `RESET_PC;
		pending         = 1'b0;
		cur_cmd         = '0;
		fetch_count     = 0;
		lsu_count       = 0;
		for (int i = 0; i < 256; i++)
		begin
			mem[i] = {$random(seed), $random(seed)};
			for (int b = 0; b < 8; b++)
				shadow[8*i + b] = mem[i][8*b +: 8];
		end
		repeat (4) @(posedge clk);
		#1;
		check_value("fetch_valid in reset", fetch_valid, 1'b0);
		check_value("l15_req_val in reset", l15_req_val, 1'b0);
		check_value("lsu_busy in reset", lsu_busy, 1'b0);
		check_value("lsu_result_valid in reset", lsu_result_valid, 1'b0);
		nrst = 1'b1;
		// Fetch only, then mixed traffic, then mostly load/store
		for (int phase = 0; phase < PHASES; phase++)
		begin
			fetch_mark = fetch_count;
			lsu_mark   = lsu_count;
			repeat (PHASE_CYCLES)
			begin
				@(posedge clk);
				#1;
				observe();
				drive(phase);
			end
			check_value("fetch progress", fetch_count > fetch_mark, 1'b1);
			if (phase != 0)
				check_value("lsu progress", lsu_count > lsu_mark, 1'b1);
		end
		while (pending)
		begin
			@(posedge clk);
			#1;
			observe();
			redirect      = 1'b0;
			lsu_cmd_valid = 1'b0;
			fetch_stall   = 1'b0;
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

/* bench/core_mem_asserts.sv */
module core_mem_asserts (
	input logic                   clk,
	input logic                   nrst,
	input core_mem_pkg::l15_req_t l15_req,
	input logic                   l15_req_val,
	input logic                   l15_header_ack,
	input logic                   l15_resp_val,
	input logic                   l15_req_ack,
	input core_mem_pkg::owner_e   owner,
	input logic                   outstanding,
	input logic                   fetch_header_ack,
	input logic                   lsu_header_ack
);

	// A request waiting for its header ack holds still
	req_stable: assert property (@(posedge clk) disable iff (!nrst)
		l15_req_val && !l15_header_ack |=> l15_req_val && $stable(l15_req))
		else $error("L1.5 request changed or dropped before its header ack");

	owner_hold: assert property (@(posedge clk) disable iff (!nrst)
		outstanding |=> owner == $past(owner))
		else $error("Port owner changed with a transaction outstanding");

	// Header acks go to the owner only
	fetch_ack_owner: assert property (@(posedge clk) disable iff (!nrst)
		owner == core_mem_pkg::OWN_LSU |-> !fetch_header_ack)
		else $error("Fetch unit saw a header ack while not owning the port");

	lsu_ack_owner: assert property (@(posedge clk) disable iff (!nrst)
		owner == core_mem_pkg::OWN_FETCH |-> !lsu_header_ack)
		else $error("Load/store unit saw a header ack while not owning the port");

	req_ack_echo: assert property (@(posedge clk) disable iff (!nrst)
		l15_req_ack == l15_resp_val)
		else $error("Request ack differs from response valid");

endmodule

bind l15_port_arbiter core_mem_asserts u_core_mem_asserts (.*);

/* verilog/core_mem_subsys.sv */
module core_mem_subsys (
	input  logic                      clk,
	input  logic                      nrst,
	input  logic                      redirect,
	input  logic [31:0]               redirect_target,
	input  logic                      fetch_stall,
	output logic                      fetch_valid,
	output core_mem_pkg::fetch_out_t  fetch_out,
	input  logic                      lsu_cmd_valid,
	input  core_mem_pkg::lsu_cmd_t    lsu_cmd,
	output logic                      lsu_busy,
	output logic                      lsu_result_valid,
	output core_mem_pkg::lsu_result_t lsu_result,
	output core_mem_pkg::l15_req_t    l15_req,
	output logic                      l15_req_val,
	input  logic                      l15_header_ack,
	input  logic                      l15_resp_val,
	input  core_mem_pkg::l15_resp_t   l15_resp,
	output logic                      l15_req_ack
);

	core_mem_pkg::l15_req_t fetch_req;
	logic                   fetch_req_val;
	logic                   fetch_header_ack;
	logic                   fetch_resp_val;
	logic                   fetch_req_ack;

	core_mem_pkg::l15_req_t lsu_req;
	logic                   lsu_req_val;
	logic                   lsu_header_ack;
	logic                   lsu_resp_val;
	logic                   lsu_req_ack;

	fetch_unit u_fetch_unit (
		.clk             (clk),
		.nrst            (nrst),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.fetch_stall     (fetch_stall),
		.req             (fetch_req),
		.req_val         (fetch_req_val),
		.header_ack      (fetch_header_ack),
		.resp_val        (fetch_resp_val),
		.resp            (l15_resp),          // Data fans out to both units
		.req_ack         (fetch_req_ack),
		.fetch_valid     (fetch_valid),
		.fetch_out       (fetch_out)
	);

	load_store_unit u_load_store_unit (
		.clk          (clk),
		.nrst         (nrst),
		.cmd_valid    (lsu_cmd_valid),
		.cmd          (lsu_cmd),
		.busy         (lsu_busy),
		.req          (lsu_req),
		.req_val      (lsu_req_val),
		.header_ack   (lsu_header_ack),
		.resp_val     (lsu_resp_val),
		.resp         (l15_resp),
		.req_ack      (lsu_req_ack),
		.result_valid (lsu_result_valid),
		.result       (lsu_result)
	);

	l15_port_arbiter u_l15_port_arbiter (
		.clk              (clk),
		.nrst             (nrst),
		.fetch_req        (fetch_req),
		.fetch_req_val    (fetch_req_val),
		.fetch_header_ack (fetch_header_ack),
		.fetch_resp_val   (fetch_resp_val),
		.fetch_req_ack    (fetch_req_ack),
		.lsu_req          (lsu_req),
		.lsu_req_val      (lsu_req_val),
		.lsu_header_ack   (lsu_header_ack),
		.lsu_resp_val     (lsu_resp_val),
		.lsu_req_ack      (lsu_req_ack),
		.l15_req          (l15_req),
		.l15_req_val      (l15_req_val),
		.l15_header_ack   (l15_header_ack),
		.l15_resp_val     (l15_resp_val),
		.l15_req_ack      (l15_req_ack)
	);

endmodule

/* verilog/l15_port_arbiter.sv */
module l15_port_arbiter (
	input  logic                   clk,
	input  logic                   nrst,

	// Fetch side
	input  core_mem_pkg::l15_req_t fetch_req,
	input  logic                   fetch_req_val,
	output logic                   fetch_header_ack,
	output logic                   fetch_resp_val,
	input  logic                   fetch_req_ack,

	// Load/store side
	input  core_mem_pkg::l15_req_t lsu_req,
	input  logic                   lsu_req_val,
	output logic                   lsu_header_ack,
	output logic                   lsu_resp_val,
	input  logic                   lsu_req_ack,

	// Shared L1.5 port
	output core_mem_pkg::l15_req_t l15_req,
	output logic                   l15_req_val,
	input  logic                   l15_header_ack,
	input  logic                   l15_resp_val,
	output logic                   l15_req_ack
);

	core_mem_pkg::owner_e owner;
	logic                 outstanding;   // Header acked, response pending
	logic                 lsu_owns;
	logic                 owner_val;

	assign lsu_owns  = (owner == core_mem_pkg::OWN_LSU);
	assign owner_val = lsu_owns ? lsu_req_val : fetch_req_val;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			owner       <= core_mem_pkg::OWN_FETCH;
			outstanding <= 1'b0;
		end
		else
		begin
			if (l15_header_ack && l15_req_val)
				outstanding <= 1'b1;
			else if (l15_resp_val)
				outstanding <= 1'b0;

			// Handover only with the port quiet
			if (!outstanding && !owner_val)
			begin
				if (lsu_req_val)
					owner <= core_mem_pkg::OWN_LSU;   // Data access wins
				else
					owner <= core_mem_pkg::OWN_FETCH;
			end
		end
	end

	always_comb
	begin
		if (lsu_owns)
		begin
			l15_req     = lsu_req;
			l15_req_val = lsu_req_val;
			l15_req_ack = lsu_req_ack;
		end
		else
		begin
			l15_req     = fetch_req;
			l15_req_val = fetch_req_val;
			l15_req_ack = fetch_req_ack;
		end
	end

	// Strobes reach the owner only
	assign fetch_header_ack = l15_header_ack && !lsu_owns;
	assign fetch_resp_val   = l15_resp_val && !lsu_owns;
	assign lsu_header_ack   = l15_header_ack && lsu_owns;
	assign lsu_resp_val     = l15_resp_val && lsu_owns;

endmodule

/* verilog/load_store_unit.sv */
`include "core_mem_defs.svh"

module load_store_unit (
	input  logic                      clk,
	input  logic                      nrst,
	input  logic                      cmd_valid,
	input  core_mem_pkg::lsu_cmd_t    cmd,
	output logic                      busy,
	output core_mem_pkg::l15_req_t    req,
	output logic                      req_val,
	input  logic                      header_ack,
	input  logic                      resp_val,
	input  core_mem_pkg::l15_resp_t   resp,
	output logic                      req_ack,
	output logic                      result_valid,
	output core_mem_pkg::lsu_result_t result
);

	core_mem_pkg::lsu_cmd_t cmd_q;
	logic                   wait_resp;
	logic                   accept;
	logic                   cmd_misal;
	logic                   is_store;
	logic [63:0]            shifted;
	logic [31:0]            load_data;

	function automatic logic misaligned(input core_mem_pkg::lsu_cmd_t c);
		case (c.op)
			core_mem_pkg::LSU_LH,
			core_mem_pkg::LSU_LHU,
			core_mem_pkg::LSU_SH: return c.addr[0];
			core_mem_pkg::LSU_LW,
			core_mem_pkg::LSU_SW: return |c.addr[1:0];
			default:              return 1'b0;
		endcase
	endfunction

	assign accept    = cmd_valid && !busy;
	assign cmd_misal = misaligned(cmd);
	assign is_store  = cmd_q.op inside {core_mem_pkg::LSU_SB, core_mem_pkg::LSU_SH,
		core_mem_pkg::LSU_SW};
	assign req_ack   = resp_val;

	always_comb
	begin
		req         = '0;
		req.rqtype  = is_store ? `L15_RQ_STORE : `L15_RQ_LOAD;
		req.address = cmd_q.addr;
		case (cmd_q.op)
			core_mem_pkg::LSU_LB, core_mem_pkg::LSU_LBU, core_mem_pkg::LSU_SB:
			begin
				req.size = `L15_SIZE_1B;
				req.data = {24'b0, cmd_q.data[7:0]};
			end
			core_mem_pkg::LSU_LH, core_mem_pkg::LSU_LHU, core_mem_pkg::LSU_SH:
			begin
				req.size = `L15_SIZE_2B;
				req.data = {16'b0, cmd_q.data[15:0]};
			end
			default:
			begin
				req.size = `L15_SIZE_4B;
				req.data = cmd_q.data;
			end
		endcase
	end

	// Bring the addressed byte down to bit 0
	assign shifted = resp.data >> {cmd_q.addr[2:0], 3'b000};

	always_comb
	begin
		case (cmd_q.op)
			core_mem_pkg::LSU_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
			core_mem_pkg::LSU_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
			core_mem_pkg::LSU_LW:  load_data = shifted[31:0];
			core_mem_pkg::LSU_LBU: load_data = {24'b0, shifted[7:0]};
			core_mem_pkg::LSU_LHU: load_data = {16'b0, shifted[15:0]};
			default:               load_data = 32'b0;   // Stores return nothing
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			busy         <= 1'b0;
			req_val      <= 1'b0;
			wait_resp    <= 1'b0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= 1'b0;
			if (accept)
			begin
				busy <= 1'b1;
				if (cmd_misal)
					result_valid <= 1'b1;   // Answered locally
				else
					req_val <= 1'b1;
			end
			else if (busy && !req_val && !wait_resp)
				busy <= 1'b0;
			if (req_val && header_ack)
			begin
				req_val   <= 1'b0;
				wait_resp <= 1'b1;
			end
			if (resp_val)
			begin
				wait_resp    <= 1'b0;
				busy         <= 1'b0;
				result_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd_q             <= cmd;
			result.tag        <= cmd.tag;
			result.data       <= 32'b0;
			result.misaligned <= cmd_misal;
		end
		else if (resp_val)
			result.data <= load_data;
	end

endmodule

/* verilog/fetch_unit.sv */
`include "core_mem_defs.svh"

module fetch_unit (
	input  logic                     clk,
	input  logic                     nrst,
	input  logic                     redirect,
	input  logic [31:0]              redirect_target,
	input  logic                     fetch_stall,
	output core_mem_pkg::l15_req_t   req,
	output logic                     req_val,
	input  logic                     header_ack,
	input  logic                     resp_val,
	input  core_mem_pkg::l15_resp_t  resp,
	output logic                     req_ack,
	output logic                     fetch_valid,
	output core_mem_pkg::fetch_out_t fetch_out
);

	logic [31:0] pc;
	logic        wait_resp;     // Header taken, data still to come
	logic        redir_pend;
	logic [31:0] redir_target;
	logic        busy;
	logic        drop;
	logic [31:0] next_pc;

	assign busy = req_val || wait_resp;

	// A redirect seen during the transaction kills its data
	assign drop = redir_pend || redirect;

	always_comb
	begin
		if (redirect)
			next_pc = redirect_target;
		else if (redir_pend)
			next_pc = redir_target;
		else
			next_pc = pc + 32'd4;
	end

	always_comb
	begin
		req         = '0;
		req.rqtype  = `L15_RQ_IFILL;
		req.size    = `L15_SIZE_4B;
		req.address = pc;
	end

	assign req_ack = resp_val;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc          <= `RESET_PC;
			req_val     <= 1'b0;
			wait_resp   <= 1'b0;
			redir_pend  <= 1'b0;
			fetch_valid <= 1'b0;
		end
		else
		begin
			fetch_valid <= 1'b0;
			if (req_val && header_ack)
			begin
				req_val   <= 1'b0;
				wait_resp <= 1'b1;
			end
			if (resp_val)
			begin
				wait_resp   <= 1'b0;
				redir_pend  <= 1'b0;
				pc          <= next_pc;
				fetch_valid <= !drop;
				req_val     <= !fetch_stall;   // Back to back unless stalled
			end
			else if (busy)
			begin
				if (redirect)
					redir_pend <= 1'b1;
			end
			else
			begin
				// Idle, so the PC can move right away
				if (redirect)
					pc <= redirect_target;
				req_val <= !fetch_stall;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (redirect)
			redir_target <= redirect_target;
		if (resp_val)
		begin
			fetch_out.pc    <= pc;
			fetch_out.instr <= pc[2] ? resp.data[63:32] : resp.data[31:0];
		end
	end

endmodule

/* verilog/core_mem_pkg.sv */
package core_mem_pkg;

	// Request toward the L1.5
	typedef struct packed {
		logic [4:0]  rqtype;
		logic [2:0]  size;
		logic [31:0] address;
		logic [31:0] data;      // Right-aligned store data
	} l15_req_t;

	// Response from the L1.5
	typedef struct packed {
		logic [3:0]  rtntype;
		logic [63:0] data;      // Whole doubleword around the address
	} l15_resp_t;

	typedef enum logic [2:0] {
		LSU_LB,
		LSU_LH,
		LSU_LW,
		LSU_LBU,
		LSU_LHU,
		LSU_SB,
		LSU_SH,
		LSU_SW
	} lsu_op_e;

	typedef struct packed {
		lsu_op_e     op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [4:0]  tag;       // Destination register
	} lsu_cmd_t;

	typedef struct packed {
		logic [4:0]  tag;
		logic [31:0] data;
		logic        misaligned;
	} lsu_result_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_out_t;

	// Which unit currently holds the L1.5 port
	typedef enum logic {
		OWN_FETCH,
		OWN_LSU
	} owner_e;

endpackage

/* include/core_mem_defs.svh */
`ifndef CORE_MEM_DEFS_SVH
`define CORE_MEM_DEFS_SVH

// L1.5 request types
`define L15_RQ_LOAD    5'b00000
`define L15_RQ_STORE   5'b00001
`define L15_RQ_IFILL   5'b10000

// L1.5 return types
`define L15_RT_LOAD    4'b0000
`define L15_RT_IFILL   4'b0001
`define L15_RT_ST_ACK  4'b0100

// Access sizes as the L1.5 encodes them
`define L15_SIZE_1B    3'b000
`define L15_SIZE_2B    3'b001
`define L15_SIZE_4B    3'b010

// First instruction fetched out of reset
`define RESET_PC       32'h0000_0080

`endif
